/* tb.f */
logic/scope_rate_pkg.sv
logic/seven_seg_decoder.sv
logic/key_repeat_gen.sv
logic/sample_period_ctrl.sv
logic/sample_strobe_gen.sv
logic/display_refresh.sv
logic/scope_rate_top.sv
test/scope_rate_assertions.sv
test/scope_rate_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module scope_rate_tb -f tb.f -o scope_rate_sim
./obj_dir/scope_rate_sim | tee sim.log
if grep -q "Simulation finished: PASS" sim.log
then
  echo "Result: pass"
else
  echo "Result: fail"
  exit 1
fi

/* test/scope_rate_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module scope_rate_tb;

  localparam int TICK_DIV        = 10;
  localparam int REPEAT_TICKS    = 4;
  localparam int DISPLAY_TICKS   = 8;
  localparam int DEFAULT_PERIOD  = 40;
  localparam int SPEED_STEP      = 5;
  localparam int SPEED_LIMIT     = 30;
  localparam int REPEAT_CYCLES   = TICK_DIV * REPEAT_TICKS;
  localparam int DISPLAY_CYCLES  = TICK_DIV * DISPLAY_TICKS;
  localparam int IDLE_CYCLES     = 3 * DISPLAY_CYCLES;
  // Summed test length in repeat intervals at the longest holds
  localparam int TEST_INTERVALS  = (2 + 11) + (2 + 17) + (2 + 3) + 7 + 3 + 3 +
                                   3 * IDLE_CYCLES / REPEAT_CYCLES + 2;
  localparam int WATCHDOG_CYCLES = 2 * TEST_INTERVALS * REPEAT_CYCLES;

  logic                    CLK_50M;
  logic                    rst_n;
  logic                    key_up;
  logic                    key_down;
  logic                    key_reset;
  logic                    sample_strobe;
  scope_rate_pkg::period_t sample_period;
  scope_rate_pkg::seg_t    hex_out [6];

  int          value_errors;
  int          other_errors;
  int          idx;
  int          held_period;

  // Compare process state
  logic [4:0]  up_hist;
  logic [4:0]  down_hist;
  logic [4:0]  rst_hist;
  int          last_period;
  int          stable_cnt;
  int          gap_cnt;
  logic        strobe_seen;
  int          expected;
  logic [23:0] period_ext;
  int          cmp_idx;

  scope_rate_top #(
    .TICK_DIV       (TICK_DIV),
    .REPEAT_TICKS   (REPEAT_TICKS),
    .DISPLAY_TICKS  (DISPLAY_TICKS),
    .DEFAULT_PERIOD (DEFAULT_PERIOD),
    .SPEED_STEP     (SPEED_STEP),
    .SPEED_LIMIT    (SPEED_LIMIT)
  ) scope_rate_top_i (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .key_up        (key_up),
    .key_down      (key_down),
    .key_reset     (key_reset),
    .sample_period (sample_period),
    .sample_strobe (sample_strobe),
    .hex0          (hex_out[0]),
    .hex1          (hex_out[1]),
    .hex2          (hex_out[2]),
    .hex3          (hex_out[3]),
    .hex4          (hex_out[4]),
    .hex5          (hex_out[5])
  );

  // 20 ns clock
  always #10 CLK_50M = ~CLK_50M;

  // ==============================
  // Reference model
  // ==============================

  // Offset rule with reset first and cancelling keys
  function automatic int next_period(input int cur, input logic up, input logic down,
                                     input logic rst);
    int offset;
    offset = cur - DEFAULT_PERIOD;
    if (rst)
      offset = 0;
    else if (up && !down)
      offset = (offset + SPEED_STEP > SPEED_LIMIT) ? SPEED_LIMIT : offset + SPEED_STEP;
    else if (down && !up)
      offset = (offset - SPEED_STEP < -SPEED_LIMIT) ? -SPEED_LIMIT : offset - SPEED_STEP;
    return DEFAULT_PERIOD + offset;
  endfunction

  // Active-low segment pattern of one digit
  function automatic logic [6:0] seg_pattern(input logic [3:0] digit);
    logic [6:0] lit;
    // Lit segments as g f e d c b a
    case (digit)
      4'h0: lit = 7'h3f;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5b;
      4'h3: lit = 7'h4f;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6d;
      4'h6: lit = 7'h7d;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7f;
      4'h9: lit = 7'h6f;
      4'ha: lit = 7'h77;
      4'hb: lit = 7'h7c;
      4'hc: lit = 7'h39;
      4'hd: lit = 7'h5e;
      4'he: lit = 7'h79;
      4'hf: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] exp_val);
    if (actual !== exp_val)
    begin
      value_errors = value_errors + 1;
      $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, actual, exp_val, $time);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge CLK_50M);
  endtask

  // Bounded wait for the first period change after a press
  task automatic wait_for_change(input int max_cycles);
    int start;
    int n;
    start = int'(sample_period);
    n = 0;
    while (int'(sample_period) == start && n < max_cycles)
    begin
      @(negedge CLK_50M);
      n = n + 1;
    end
    if (int'(sample_period) == start)
    begin
      other_errors = other_errors + 1;
      $display("No period change within two repeat intervals of a key press at %0t", $time);
    end
  endtask

  // Hold the speed keys for whole repeat intervals, then let them settle
  task automatic press_keys(input logic up, input logic down, input int intervals,
                            input logic expect_move);
    key_up   = !up;
    key_down = !down;
    if (expect_move)
      wait_for_change(2 * REPEAT_CYCLES);
    wait_cycles(intervals * REPEAT_CYCLES);
    key_up   = 1'b1;
    key_down = 1'b1;
    wait_cycles(8);
  endtask

  task automatic finish_run();
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  endtask

  // ==============================
  // Compare process
  // ==============================

  always @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      up_hist     = '0;
      down_hist   = '0;
      rst_hist    = '0;
      last_period = DEFAULT_PERIOD;
      stable_cnt  = 0;
      gap_cnt     = 0;
      strobe_seen = 1'b0;
    end
    else
    begin
      // Pressed levels per rising edge with the newest in bit 0
      up_hist   = {up_hist[3:0], ~key_up};
      down_hist = {down_hist[3:0], ~key_down};
      rst_hist  = {rst_hist[3:0], ~key_reset};
      // Speed keys act 4 edges late and the reset key 3
      if (int'(sample_period) != last_period)
      begin
        expected = next_period(last_period, up_hist[4], down_hist[4], rst_hist[3]);
        check_value("sample_period", 32'(sample_period), 32'(expected));
        last_period = int'(sample_period);
        stable_cnt  = 0;
      end
      else
        stable_cnt = stable_cnt + 1;
      // Strobe spacing once the interval ran on a stable period
      gap_cnt = gap_cnt + 1;
      // No interval outlasts the largest period
      if (gap_cnt > DEFAULT_PERIOD + SPEED_LIMIT + 1)
      begin
        other_errors = other_errors + 1;
        $display("No sample_strobe within the longest sampling interval at %0t", $time);
        gap_cnt = 0;
      end
      if (sample_strobe)
      begin
        if (strobe_seen && stable_cnt > gap_cnt + 2)
          check_value("sample_strobe gap", 32'(gap_cnt), 32'(int'(sample_period) + 1));
        strobe_seen = 1'b1;
        gap_cnt     = 0;
      end
      // Display after two refresh intervals
      if (stable_cnt >= 2 * DISPLAY_CYCLES)
      begin
        period_ext = 24'(sample_period);
        for (cmp_idx = 0; cmp_idx < 6; cmp_idx++)
          check_value($sformatf("hex%0d", cmp_idx), 32'(hex_out[cmp_idx]),
                      32'(seg_pattern(period_ext[4*cmp_idx +: 4])));
      end
    end
  end

  // ==============================
  // Stimulus
  // ==============================

  initial
  begin
    void'($urandom(7));
    value_errors = 0;
    other_errors = 0;
    CLK_50M      = 1'b0;
    rst_n        = 1'b0;
    key_up       = 1'b1;
    key_down     = 1'b1;
    key_reset    = 1'b1;
    wait_cycles(10);
    rst_n = 1'b1;
    @(negedge CLK_50M);
    // Reset state
    check_value("sample_period", 32'(sample_period), 32'(DEFAULT_PERIOD));
    for (idx = 0; idx < 6; idx++)
      check_value($sformatf("hex%0d", idx), 32'(hex_out[idx]), 32'(seg_pattern(4'h0)));
    wait_cycles(IDLE_CYCLES);
    // Up to the upper bound
    press_keys(1'b1, 1'b0, 8 + int'($urandom % 4), 1'b1);
    check_value("sample_period", 32'(sample_period), 32'(DEFAULT_PERIOD + SPEED_LIMIT));
    wait_cycles(IDLE_CYCLES);
    // Down to the lower bound
    press_keys(1'b0, 1'b1, 14 + int'($urandom % 4), 1'b1);
    check_value("sample_period", 32'(sample_period), 32'(DEFAULT_PERIOD - SPEED_LIMIT));
    // Off the bound and then both keys together
    press_keys(1'b1, 1'b0, 3, 1'b1);
    held_period = int'(sample_period);
    press_keys(1'b1, 1'b1, 4 + int'($urandom % 4), 1'b0);
    check_value("sample_period", 32'(sample_period), 32'(held_period));
    // Reset key wins over speed keys
    key_reset = 1'b0;
    wait_cycles(10);
    check_value("sample_period", 32'(sample_period), 32'(DEFAULT_PERIOD));
    press_keys(1'b1, 1'b0, 2 + int'($urandom % 2), 1'b0);
    press_keys(1'b0, 1'b1, 2 + int'($urandom % 2), 1'b0);
    check_value("sample_period", 32'(sample_period), 32'(DEFAULT_PERIOD));
    key_reset = 1'b1;
    wait_cycles(IDLE_CYCLES);
    check_value("sample_period", 32'(sample_period), 32'(DEFAULT_PERIOD));
    finish_run();
  end

  // Watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK_50M);
    other_errors = other_errors + 1;
    $display("Timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
    finish_run();
  end

endmodule

`default_nettype wire

/* test/scope_rate_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module scope_rate_assertions #(
  parameter int DEFAULT_PERIOD = 12499,
  parameter int SPEED_STEP     = 100,
  parameter int SPEED_LIMIT    = 10000
) (
  input wire                          CLK_50M,
  input wire                          rst_n,
  input wire                          sample_strobe,
  input wire scope_rate_pkg::period_t sample_period
);

  // Strobe is a single-cycle pulse
  strobe_one_cycle: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    sample_strobe |=> !sample_strobe
  ) else $error("sample_strobe high for two cycles");

  // Period inside the speed window
  period_in_range: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    int'(sample_period) >= DEFAULT_PERIOD - SPEED_LIMIT &&
    int'(sample_period) <= DEFAULT_PERIOD + SPEED_LIMIT
  ) else $error("sample_period outside the speed window");

  // One step at a time, or straight back to the default
  period_one_step: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    int'(sample_period) != int'($past(sample_period)) |->
      (int'(sample_period) - int'($past(sample_period)) == SPEED_STEP ||
       int'($past(sample_period)) - int'(sample_period) == SPEED_STEP ||
       int'(sample_period) == DEFAULT_PERIOD)
  ) else $error("sample_period changed by more than one step");

endmodule

bind scope_rate_top scope_rate_assertions #(
  .DEFAULT_PERIOD (DEFAULT_PERIOD),
  .SPEED_STEP     (SPEED_STEP),
  .SPEED_LIMIT    (SPEED_LIMIT)
) scope_rate_assertions_i (
  .CLK_50M       (CLK_50M),
  .rst_n         (rst_n),
  .sample_strobe (sample_strobe),
  .sample_period (sample_period)
);

`default_nettype wire

/* logic/scope_rate_top.sv */
`timescale 1ns/1ns
`default_nettype none

module scope_rate_top #(
  parameter int TICK_DIV       = 50000,
  parameter int REPEAT_TICKS   = 100,
  parameter int DISPLAY_TICKS  = 500,
  parameter int DEFAULT_PERIOD = 12499,
  parameter int SPEED_STEP     = 100,
  parameter int SPEED_LIMIT    = 10000
) (
  input  wire                     CLK_50M,
  input  wire                     rst_n,
  // Board keys, asynchronous and active low
  input  wire                     key_up,
  input  wire                     key_down,
  input  wire                     key_reset,
  output scope_rate_pkg::period_t sample_period,
  output logic                    sample_strobe,
  output scope_rate_pkg::seg_t    hex0,
  output scope_rate_pkg::seg_t    hex1,
  output scope_rate_pkg::seg_t    hex2,
  output scope_rate_pkg::seg_t    hex3,
  output scope_rate_pkg::seg_t    hex4,
  output scope_rate_pkg::seg_t    hex5
);

  logic                    tick;
  logic                    up_event;
  logic                    down_event;
  logic                    reset_hold;
  scope_rate_pkg::period_t period;

  // ==============================
  // Keys and speed control
  // ==============================

  key_repeat_gen #(
    .TICK_DIV     (TICK_DIV),
    .REPEAT_TICKS (REPEAT_TICKS)
  ) key_repeat_gen_i (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .key_up     (key_up),
    .key_down   (key_down),
    .key_reset  (key_reset),
    .tick       (tick),
    .up_event   (up_event),
    .down_event (down_event),
    .reset_hold (reset_hold)
  );

  sample_period_ctrl #(
    .DEFAULT_PERIOD (DEFAULT_PERIOD),
    .SPEED_STEP     (SPEED_STEP),
    .SPEED_LIMIT    (SPEED_LIMIT)
  ) sample_period_ctrl_i (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .up_event   (up_event),
    .down_event (down_event),
    .reset_hold (reset_hold),
    .period     (period)
  );

  // ==============================
  // Strobe and display
  // ==============================

  sample_strobe_gen sample_strobe_gen_i (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .period        (period),
    .sample_strobe (sample_strobe)
  );

  // Display shares the millisecond tick
  display_refresh #(
    .DISPLAY_TICKS (DISPLAY_TICKS)
  ) display_refresh_i (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .tick    (tick),
    .period  (period),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

  assign sample_period = period;

endmodule

`default_nettype wire

/* logic/display_refresh.sv */
`timescale 1ns/1ns
`default_nettype none

module display_refresh #(
  parameter int DISPLAY_TICKS = 500
) (
  input  wire                          CLK_50M,
  input  wire                          rst_n,
  input  wire                          tick,
  input  wire scope_rate_pkg::period_t period,
  output scope_rate_pkg::seg_t         hex0,
  output scope_rate_pkg::seg_t         hex1,
  output scope_rate_pkg::seg_t         hex2,
  output scope_rate_pkg::seg_t         hex3,
  output scope_rate_pkg::seg_t         hex4,
  output scope_rate_pkg::seg_t         hex5
);

  localparam int CNT_W = $clog2(DISPLAY_TICKS + 1);

  logic [CNT_W-1:0]                 ref_cnt;
  logic [scope_rate_pkg::DISPLAY_W-1:0] shown;
  scope_rate_pkg::seg_t             segs [scope_rate_pkg::NUM_DIGITS];

  // ==============================
  // Slow refresh latch
  // ==============================

  // Latch loads on the last tick of each interval
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      ref_cnt <= '0;
      shown   <= '0;
    end
    else if (tick)
    begin
      if (ref_cnt == CNT_W'(DISPLAY_TICKS - 1))
      begin
        ref_cnt <= '0;
        shown   <= scope_rate_pkg::DISPLAY_W'(period);
      end
      else
        ref_cnt <= ref_cnt + 1'b1;
    end
  end

  // One decoder per nibble, digit 0 is the lowest
  for (genvar i = 0; i < scope_rate_pkg::NUM_DIGITS; i++)
  begin : g_digit
    seven_seg_decoder seven_seg_decoder_i (
      .digit    (shown[4*i +: 4]),
      .segments (segs[i])
    );
  end

  assign hex0 = segs[0];
  assign hex1 = segs[1];
  assign hex2 = segs[2];
  assign hex3 = segs[3];
  assign hex4 = segs[4];
  assign hex5 = segs[5];

endmodule

`default_nettype wire

/* logic/sample_strobe_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module sample_strobe_gen (
  input  wire                     CLK_50M,
  input  wire                     rst_n,
  input  wire scope_rate_pkg::period_t period,
  output logic                    sample_strobe
);

  scope_rate_pkg::period_t cnt;
  scope_rate_pkg::period_t period_cur;
  logic                    terminal;

  // Terminal count of the running interval
  assign terminal = (cnt == period_cur);

  // ==============================
  // Reloadable divider
  // ==============================

  // Reset behaves as a restart and takes the period as well
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n || terminal)
    begin
      cnt        <= '0;
      period_cur <= period;
    end
    else
      cnt <= cnt + 1'b1;
  end

  // Strobe spans the terminal cycle only
  // so strobes sit period + 1 cycles apart
  assign sample_strobe = terminal;

endmodule

`default_nettype wire

/* logic/sample_period_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module sample_period_ctrl #(
  parameter int DEFAULT_PERIOD = 12499,
  parameter int SPEED_STEP     = 100,
  parameter int SPEED_LIMIT    = 10000
) (
  input  wire                     CLK_50M,
  input  wire                     rst_n,
  input  wire                     up_event,
  input  wire                     down_event,
  input  wire                     reset_hold,
  output scope_rate_pkg::period_t period
);

  localparam scope_rate_pkg::period_t BASE_PERIOD = scope_rate_pkg::period_t'(DEFAULT_PERIOD);
  localparam scope_rate_pkg::speed_t  STEP_S      = scope_rate_pkg::speed_t'(SPEED_STEP);
  localparam scope_rate_pkg::speed_t  LIMIT_S     = scope_rate_pkg::speed_t'(SPEED_LIMIT);

  scope_rate_pkg::speed_t speed;
  scope_rate_pkg::speed_t speed_next;

  // Next offset, reset key first, then saturating steps
  always_comb
  begin
    speed_next = speed;
    if (reset_hold)
      speed_next = '0;
    else if (up_event && !down_event)
    begin
      // Clamp at the upper bound
      if (speed >= LIMIT_S - STEP_S)
        speed_next = LIMIT_S;
      else
        speed_next = speed + STEP_S;
    end
    else if (down_event && !up_event)
    begin
      // Clamp at the lower bound
      if (speed <= STEP_S - LIMIT_S)
        speed_next = -LIMIT_S;
      else
        speed_next = speed - STEP_S;
    end
  end

  // Period registered from the next offset, so it follows an event by one cycle
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      speed  <= '0;
      period <= BASE_PERIOD;
    end
    else
    begin
      speed  <= speed_next;
      period <= BASE_PERIOD + scope_rate_pkg::period_t'(speed_next);
    end
  end

endmodule

`default_nettype wire

/* logic/key_repeat_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module key_repeat_gen #(
  parameter int TICK_DIV     = 50000,
  parameter int REPEAT_TICKS = 100
) (
  input  wire  CLK_50M,
  input  wire  rst_n,
  input  wire  key_up,
  input  wire  key_down,
  input  wire  key_reset,
  output logic tick,
  output logic up_event,
  output logic down_event,
  output logic reset_hold
);

  localparam int TICK_W = $clog2(TICK_DIV + 1);
  localparam int REP_W  = $clog2(REPEAT_TICKS + 1);

  // Key order in the vectors: reset, down, up
  logic [2:0]        key_meta;
  logic [2:0]        key_sync;
  logic [TICK_W-1:0] tick_cnt;
  logic [REP_W-1:0]  rep_cnt;
  logic              rep_last;

  // ==============================
  // Key synchronizers
  // ==============================

  // Keys are active low on the pins, pressed reads as 1 here
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= {~key_reset, ~key_down, ~key_up};
      key_sync <= key_meta;
    end
  end

  // Reset key acts as a level, no repeat
  assign reset_hold = key_sync[2];

  // ==============================
  // Millisecond tick
  // ==============================

  // One tick pulse per TICK_DIV cycles
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      tick_cnt <= '0;
      tick     <= 1'b0;
    end
    else if (tick_cnt == TICK_W'(TICK_DIV - 1))
    begin
      tick_cnt <= '0;
      tick     <= 1'b1;
    end
    else
    begin
      tick_cnt <= tick_cnt + 1'b1;
      tick     <= 1'b0;
    end
  end

  // ==============================
  // Auto-repeat events
  // ==============================

  // Last tick of the repeat interval
  assign rep_last = (rep_cnt == REP_W'(REPEAT_TICKS - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      rep_cnt    <= '0;
      up_event   <= 1'b0;
      down_event <= 1'b0;
    end
    else
    begin
      // Events only on the boundary tick
      up_event   <= tick && rep_last && key_sync[0];
      down_event <= tick && rep_last && key_sync[1];
      if (tick)
      begin
        if (rep_last)
          rep_cnt <= '0;
        else
          rep_cnt <= rep_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/seven_seg_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module seven_seg_decoder (
  input  wire scope_rate_pkg::digit_t digit,
  output scope_rate_pkg::seg_t        segments
);

  // Pattern order is g f e d c b a
  // A zero bit lights the segment
  always_comb
  begin
    case (digit)
      4'h0: segments = 7'b1000000;
      4'h1: segments = 7'b1111001;
      4'h2: segments = 7'b0100100;
      4'h3: segments = 7'b0110000;
      4'h4: segments = 7'b0011001;
      4'h5: segments = 7'b0010010;
      4'h6: segments = 7'b0000010;
      4'h7: segments = 7'b1111000;
      4'h8: segments = 7'b0000000;
      4'h9: segments = 7'b0010000;
      // Letters, b and d in lower case
      4'ha: segments = 7'b0001000;
      4'hb: segments = 7'b0000011;
      4'hc: segments = 7'b1000110;
      4'hd: segments = 7'b0100001;
      4'he: segments = 7'b0000110;
      4'hf: segments = 7'b0001110;
    endcase
  end

endmodule

`default_nettype wire

/* logic/scope_rate_pkg.sv */
`default_nettype none

package scope_rate_pkg;

  // ==============================
  // Vector types of the rate path
  // ==============================

  // Sample period in CLK_50M cycles, minus one
  typedef logic [15:0] period_t;

  // Signed offset added to the default period
  typedef logic signed [15:0] speed_t;

  // One hexadecimal display digit
  typedef logic [3:0] digit_t;

  // Segment pattern, active low, bit 0 is segment a
  typedef logic [6:0] seg_t;

  // ==============================
  // Display geometry
  // ==============================

  // Number of seven-segment displays on the board
  localparam int NUM_DIGITS = 6;

  // Width of the display latch, period zero-extended to it
  localparam int DISPLAY_W = NUM_DIGITS * $bits(digit_t);

endpackage

`default_nettype wire
